// File: common/roce_params.svh
`ifndef ROCE_PARAMS_SVH
`define ROCE_PARAMS_SVH

// payload datapath
`define ROCE_DATA_W 64
`define ROCE_KEEP_W 8

// RC RDMA acknowledge opcode
`define ROCE_OP_ACK 8'h11

// RoCE v2 well-known UDP port
`define ROCE_UDP_PORT 16'd4791

// register port address width
`define ROCE_REG_ADDR_W 2

// register map
// cfg bit 0 is the ICRC check enable
`define ROCE_REG_CFG 2'd0
`define ROCE_REG_ACCEPT_CNT 2'd1
`define ROCE_REG_DROP_CNT 2'd2
`define ROCE_REG_ICRC_ERR_CNT 2'd3

// event counter width
`define ROCE_CNT_W 16

`endif

// File: common/roce_pkg.sv
`include "roce_params.svh"

package roce_pkg;

  // payload stream
  typedef logic [`ROCE_DATA_W-1:0] roce_word_t;
  typedef logic [`ROCE_KEEP_W-1:0] roce_keep_t;

  // BTH fields
  typedef logic [7:0] opcode_t;
  typedef logic [15:0] pkey_t;
  typedef logic [23:0] qpn_t;
  typedef logic [23:0] psn_t;

  // AETH fields
  typedef logic [7:0] syndrome_t;
  typedef logic [23:0] msn_t;

  // trailer
  typedef logic [31:0] icrc_t;

  // from the IP / UDP headers
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // status and config
  typedef logic [`ROCE_CNT_W-1:0] stat_cnt_t;
  typedef logic [15:0] reg_data_t;

  // receive sequencing
  // hdr words covers BTH, AETH and the ICRC word
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HDR_WORDS,
    RX_CHECK,
    RX_DISCARD
  } rx_state_t;

endpackage

// File: roce_rx/roce_rx_fsm.sv
`timescale 1ns/1ps

module roce_rx_fsm
  import roce_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       s_hdr_valid,
  output logic       s_hdr_ready,
  input  logic       s_payload_valid,
  input  logic       s_payload_last,
  output logic       s_payload_ready,
  output logic       m_ack_valid,
  input  logic       m_ack_ready,
  input  logic       is_ack,
  input  logic       icrc_match,
  input  logic       icrc_check_en,
  output logic       hdr_store,
  output logic       word_store,
  output logic [1:0] word_idx,
  output logic       ev_accept,
  output logic       ev_drop,
  output logic       ev_icrc_err,
  output logic       error_early_term,
  output logic       busy
);

  rx_state_t state, state_next;

  logic hdr_ready_q, hdr_ready_next;
  logic pay_ready_q, pay_ready_next;
  logic ack_valid_q, ack_valid_next;
  logic [1:0] idx_q, idx_next;
  logic accept_next, drop_next, icrc_err_next, early_next;
  logic accept_q, drop_q, icrc_err_q, early_q;

  logic hdr_xfer;
  logic pay_xfer;

  assign hdr_xfer = s_hdr_valid && hdr_ready_q;
  assign pay_xfer = s_payload_valid && pay_ready_q;

  // datapath strobes to the extractor
  assign hdr_store  = hdr_xfer;
  assign word_store = pay_xfer && (state == RX_HDR_WORDS);
  assign word_idx   = idx_q;

  assign s_hdr_ready      = hdr_ready_q;
  assign s_payload_ready  = pay_ready_q;
  assign m_ack_valid      = ack_valid_q;
  assign ev_accept        = accept_q;
  assign ev_drop          = drop_q;
  assign ev_icrc_err      = icrc_err_q;
  assign error_early_term = early_q;
  assign busy             = (state != RX_IDLE);

  always_comb begin
    state_next     = state;
    pay_ready_next = pay_ready_q;
    idx_next       = idx_q;
    // output holds until the sink takes it
    ack_valid_next = ack_valid_q && !m_ack_ready;
    accept_next    = 1'b0;
    drop_next      = 1'b0;
    icrc_err_next  = 1'b0;
    early_next     = 1'b0;

    case (state)
      RX_IDLE: begin
        if (hdr_xfer) begin
          state_next     = RX_HDR_WORDS;
          pay_ready_next = 1'b1;
          idx_next       = 2'd0;
        end
      end
      RX_HDR_WORDS: begin
        if (pay_xfer) begin
          if (idx_q != 2'd2) begin
            if (s_payload_last) begin
              // frame ended inside BTH / AETH
              early_next     = 1'b1;
              drop_next      = 1'b1;
              pay_ready_next = 1'b0;
              state_next     = RX_IDLE;
            end else begin
              idx_next = idx_q + 2'd1;
            end
          end else if (s_payload_last) begin
            // ICRC word closes the frame
            pay_ready_next = 1'b0;
            state_next     = RX_CHECK;
          end else begin
            // too long for an ACK so the rest is eaten
            drop_next  = 1'b1;
            state_next = RX_DISCARD;
          end
        end
      end
      RX_CHECK: begin
        state_next = RX_IDLE;
        if (!is_ack) begin
          drop_next = 1'b1;
        end else if (icrc_check_en && !icrc_match) begin
          icrc_err_next = 1'b1;
        end else begin
          ack_valid_next = 1'b1;
          accept_next    = 1'b1;
        end
      end
      RX_DISCARD: begin
        if (pay_xfer && s_payload_last) begin
          pay_ready_next = 1'b0;
          state_next     = RX_IDLE;
        end
      end
      default: begin
        state_next = RX_IDLE;
      end
    endcase

    // header accepted only when idle and no ACK is waiting
    hdr_ready_next = (state_next == RX_IDLE) && !ack_valid_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= RX_IDLE;
      hdr_ready_q <= 1'b0;
      pay_ready_q <= 1'b0;
      ack_valid_q <= 1'b0;
      idx_q       <= 2'd0;
      accept_q    <= 1'b0;
      drop_q      <= 1'b0;
      icrc_err_q  <= 1'b0;
      early_q     <= 1'b0;
    end else begin
      state       <= state_next;
      hdr_ready_q <= hdr_ready_next;
      pay_ready_q <= pay_ready_next;
      ack_valid_q <= ack_valid_next;
      idx_q       <= idx_next;
      accept_q    <= accept_next;
      drop_q      <= drop_next;
      icrc_err_q  <= icrc_err_next;
      early_q     <= early_next;
    end
  end

  // output valid held until taken
  a_ack_hold: assert property (@(posedge clk) disable iff (rst)
    m_ack_valid && !m_ack_ready |=> m_ack_valid);

  // no new header while an ACK is pending
  a_hdr_stall: assert property (@(posedge clk) disable iff (rst)
    !(s_hdr_ready && m_ack_valid));

endmodule

// File: roce_rx/roce_ack_extract.sv
`timescale 1ns/1ps

`include "roce_params.svh"

module roce_ack_extract
  import roce_pkg::*;
(
  input  logic       clk,
  input  ip_addr_t   s_ip_source_ip,
  input  udp_port_t  s_udp_source_port,
  input  udp_port_t  s_udp_dest_port,
  input  icrc_t      s_computed_icrc,
  input  roce_word_t s_payload_data,
  input  roce_keep_t s_payload_keep,
  input  logic       hdr_store,
  input  logic       word_store,
  input  logic [1:0] word_idx,
  output opcode_t    m_ack_opcode,
  output pkey_t      m_ack_p_key,
  output qpn_t       m_ack_dest_qp,
  output logic       m_ack_ack_req,
  output psn_t       m_ack_psn,
  output syndrome_t  m_ack_syndrome,
  output msn_t       m_ack_msn,
  output ip_addr_t   m_ack_ip_source_ip,
  output udp_port_t  m_ack_udp_source_port,
  output logic       is_ack,
  output logic       icrc_match
);

  udp_port_t dest_port_q;
  icrc_t     icrc_calc_q;
  icrc_t     icrc_rx_q;
  logic      icrc_keep_q;

  // header beat, only what the ACK path needs
  always_ff @(posedge clk) begin
    if (hdr_store) begin
      m_ack_ip_source_ip    <= s_ip_source_ip;
      m_ack_udp_source_port <= s_udp_source_port;
      dest_port_q           <= s_udp_dest_port;
      icrc_calc_q           <= s_computed_icrc;
    end
  end

  // payload bytes arrive lowest lane first, fields are big endian
  always_ff @(posedge clk) begin
    if (word_store) begin
      case (word_idx)
        2'd0: begin
          // BTH bytes 0..7
          m_ack_opcode  <= s_payload_data[7:0];
          m_ack_p_key   <= {s_payload_data[23:16], s_payload_data[31:24]};
          // byte 4 reserved
          m_ack_dest_qp <= {s_payload_data[47:40], s_payload_data[55:48],
                            s_payload_data[63:56]};
        end
        2'd1: begin
          // BTH bytes 8..11
          m_ack_ack_req  <= s_payload_data[7];
          m_ack_psn      <= {s_payload_data[15:8], s_payload_data[23:16],
                             s_payload_data[31:24]};
          // AETH
          m_ack_syndrome <= s_payload_data[39:32];
          m_ack_msn      <= {s_payload_data[47:40], s_payload_data[55:48],
                             s_payload_data[63:56]};
        end
        2'd2: begin
          // received ICRC in the low four lanes
          icrc_rx_q   <= {s_payload_data[7:0], s_payload_data[15:8],
                          s_payload_data[23:16], s_payload_data[31:24]};
          icrc_keep_q <= &s_payload_keep[3:0];
        end
        default: begin
          icrc_keep_q <= 1'b0;
        end
      endcase
    end
  end

  // both rules must hold, opcode and port
  assign is_ack = (m_ack_opcode == `ROCE_OP_ACK) && (dest_port_q == `ROCE_UDP_PORT);

  // all four ICRC bytes present and equal to the upstream value
  assign icrc_match = icrc_keep_q && (icrc_rx_q == icrc_calc_q);

endmodule

// File: roce_rx/roce_rx_regs.sv
`timescale 1ns/1ps

`include "roce_params.svh"

module roce_rx_regs
  import roce_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        reg_req,
  input  logic                        reg_we,
  input  logic [`ROCE_REG_ADDR_W-1:0] reg_addr,
  input  reg_data_t                   reg_wdata,
  output logic                        reg_ack,
  output reg_data_t                   reg_rdata,
  output logic                        icrc_check_en,
  input  logic                        ev_accept,
  input  logic                        ev_drop,
  input  logic                        ev_icrc_err
);

  stat_cnt_t accept_cnt;
  stat_cnt_t drop_cnt;
  stat_cnt_t icrc_err_cnt;

  logic access;
  logic clr_accept, clr_drop, clr_icrc_err;

  // one access per handshake, on the edge that raises ack
  assign access = reg_req && !reg_ack;

  // a write to a counter address clears it
  assign clr_accept   = access && reg_we && (reg_addr == `ROCE_REG_ACCEPT_CNT);
  assign clr_drop     = access && reg_we && (reg_addr == `ROCE_REG_DROP_CNT);
  assign clr_icrc_err = access && reg_we && (reg_addr == `ROCE_REG_ICRC_ERR_CNT);

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_ack       <= 1'b0;
      icrc_check_en <= 1'b1;
    end else begin
      // ack follows req one cycle late, both edges
      reg_ack <= reg_req;
      if (access && reg_we && (reg_addr == `ROCE_REG_CFG)) begin
        icrc_check_en <= reg_wdata[0];
      end
    end
  end

  // saturating counters, clear wins over a same-cycle event
  always_ff @(posedge clk) begin
    if (rst) begin
      accept_cnt   <= '0;
      drop_cnt     <= '0;
      icrc_err_cnt <= '0;
    end else begin
      if (clr_accept) begin
        accept_cnt <= '0;
      end else if (ev_accept && !(&accept_cnt)) begin
        accept_cnt <= accept_cnt + 1'b1;
      end
      if (clr_drop) begin
        drop_cnt <= '0;
      end else if (ev_drop && !(&drop_cnt)) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
      if (clr_icrc_err) begin
        icrc_err_cnt <= '0;
      end else if (ev_icrc_err && !(&icrc_err_cnt)) begin
        icrc_err_cnt <= icrc_err_cnt + 1'b1;
      end
    end
  end

  // read data captured with the access, valid while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      case (reg_addr)
        `ROCE_REG_CFG:          reg_rdata <= {15'd0, icrc_check_en};
        `ROCE_REG_ACCEPT_CNT:   reg_rdata <= accept_cnt;
        `ROCE_REG_DROP_CNT:     reg_rdata <= drop_cnt;
        `ROCE_REG_ICRC_ERR_CNT: reg_rdata <= icrc_err_cnt;
        default:                reg_rdata <= '0;
      endcase
    end
  end

  // ack only ever answers a request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(reg_ack) |-> $past(reg_req));

endmodule

// File: verilog/roce_rx_top.sv
`timescale 1ns/1ps

`include "roce_params.svh"

module roce_rx_top
  import roce_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  // header beat
  input  logic                        s_hdr_valid,
  output logic                        s_hdr_ready,
  input  ip_addr_t                    s_ip_source_ip,
  input  udp_port_t                   s_udp_source_port,
  input  udp_port_t                   s_udp_dest_port,
  input  icrc_t                       s_computed_icrc,
  // payload stream
  input  logic                        s_payload_valid,
  output logic                        s_payload_ready,
  input  roce_word_t                  s_payload_data,
  input  roce_keep_t                  s_payload_keep,
  input  logic                        s_payload_last,
  // decoded acknowledge
  output logic                        m_ack_valid,
  input  logic                        m_ack_ready,
  output opcode_t                     m_ack_opcode,
  output pkey_t                       m_ack_p_key,
  output qpn_t                        m_ack_dest_qp,
  output logic                        m_ack_ack_req,
  output psn_t                        m_ack_psn,
  output syndrome_t                   m_ack_syndrome,
  output msn_t                        m_ack_msn,
  output ip_addr_t                    m_ack_ip_source_ip,
  output udp_port_t                   m_ack_udp_source_port,
  // register port
  input  logic                        reg_req,
  input  logic                        reg_we,
  input  logic [`ROCE_REG_ADDR_W-1:0] reg_addr,
  input  reg_data_t                   reg_wdata,
  output logic                        reg_ack,
  output reg_data_t                   reg_rdata,
  // status
  output logic                        busy,
  output logic                        error_early_term
);

  logic       hdr_store;
  logic       word_store;
  logic [1:0] word_idx;
  logic       is_ack;
  logic       icrc_match;
  logic       icrc_check_en;
  logic       ev_accept;
  logic       ev_drop;
  logic       ev_icrc_err;

  roce_rx_fsm fsm_i (
    .clk              (clk),
    .rst              (rst),
    .s_hdr_valid      (s_hdr_valid),
    .s_hdr_ready      (s_hdr_ready),
    .s_payload_valid  (s_payload_valid),
    .s_payload_last   (s_payload_last),
    .s_payload_ready  (s_payload_ready),
    .m_ack_valid      (m_ack_valid),
    .m_ack_ready      (m_ack_ready),
    .is_ack           (is_ack),
    .icrc_match       (icrc_match),
    .icrc_check_en    (icrc_check_en),
    .hdr_store        (hdr_store),
    .word_store       (word_store),
    .word_idx         (word_idx),
    .ev_accept        (ev_accept),
    .ev_drop          (ev_drop),
    .ev_icrc_err      (ev_icrc_err),
    .error_early_term (error_early_term),
    .busy             (busy)
  );

  roce_ack_extract extract_i (
    .clk                   (clk),
    .s_ip_source_ip        (s_ip_source_ip),
    .s_udp_source_port     (s_udp_source_port),
    .s_udp_dest_port       (s_udp_dest_port),
    .s_computed_icrc       (s_computed_icrc),
    .s_payload_data        (s_payload_data),
    .s_payload_keep        (s_payload_keep),
    .hdr_store             (hdr_store),
    .word_store            (word_store),
    .word_idx              (word_idx),
    .m_ack_opcode          (m_ack_opcode),
    .m_ack_p_key           (m_ack_p_key),
    .m_ack_dest_qp         (m_ack_dest_qp),
    .m_ack_ack_req         (m_ack_ack_req),
    .m_ack_psn             (m_ack_psn),
    .m_ack_syndrome        (m_ack_syndrome),
    .m_ack_msn             (m_ack_msn),
    .m_ack_ip_source_ip    (m_ack_ip_source_ip),
    .m_ack_udp_source_port (m_ack_udp_source_port),
    .is_ack                (is_ack),
    .icrc_match            (icrc_match)
  );

  roce_rx_regs regs_i (
    .clk           (clk),
    .rst           (rst),
    .reg_req       (reg_req),
    .reg_we        (reg_we),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_ack       (reg_ack),
    .reg_rdata     (reg_rdata),
    .icrc_check_en (icrc_check_en),
    .ev_accept     (ev_accept),
    .ev_drop       (ev_drop),
    .ev_icrc_err   (ev_icrc_err)
  );

endmodule

// File: testbench/tb_roce_rx_vectors.svh
`ifndef TB_ROCE_RX_VECTORS_SVH
`define TB_ROCE_RX_VECTORS_SVH

// one decoded acknowledge, in output port order
typedef struct packed {
  opcode_t   opcode;
  pkey_t     p_key;
  qpn_t      dest_qp;
  logic      ack_req;
  psn_t      psn;
  syndrome_t syndrome;
  msn_t      msn;
  ip_addr_t  ip_source_ip;
  udp_port_t udp_source_port;
} ack_fields_t;

// frame outcome
localparam logic [1:0] VERDICT_ACCEPT = 2'd0;
localparam logic [1:0] VERDICT_DROP   = 2'd1;
localparam logic [1:0] VERDICT_ICRC   = 2'd2;
localparam logic [1:0] VERDICT_EARLY  = 2'd3;

// header beat, payload words, word count, check enable, outcome, hold, decoded fields
typedef struct packed {
  ip_addr_t    ip;
  udp_port_t   sport;
  udp_port_t   dport;
  icrc_t       calc_icrc;
  roce_word_t  w0;
  roce_word_t  w1;
  roce_word_t  w2;
  int          words;
  logic        check_en;
  logic [1:0]  verdict;
  logic        hold;
  ack_fields_t exp;
} frame_vec_t;

localparam int NUM_VECS = 9;

// wire words, frame byte 0 sits in lane 0
// A: pkey ffff qp 000123 ackreq psn 00abcd syn 1f msn 000042 icrc deadbeef
localparam roce_word_t BTH_A  = 64'h2301_0000_ffff_0011;
localparam roce_word_t AETH_A = 64'h4200_001f_cdab_0080;
localparam roce_word_t ICRC_A = 64'h0000_0000_efbe_adde;
// B: pkey 1234 qp abcdef psn 123456 syn 60 msn 789abc icrc 01020304
localparam roce_word_t BTH_B  = 64'hefcd_ab00_3412_0011;
localparam roce_word_t AETH_B = 64'hbc9a_7860_5634_1200;
localparam roce_word_t ICRC_B = 64'h0000_0000_0403_0201;
// A with opcode 0a, an RDMA write only
localparam roce_word_t BTH_WR = 64'h2301_0000_ffff_000a;

frame_vec_t vecs [NUM_VECS];

task automatic load_vectors();
  vecs[0] = '{32'h0a00_0001, 16'hc001, 16'd4791, 32'hdeadbeef, BTH_A, AETH_A, ICRC_A,
              3, 1'b1, VERDICT_ACCEPT, 1'b0,
              '{8'h11, 16'hffff, 24'h000123, 1'b1, 24'h00abcd, 8'h1f, 24'h000042,
                32'h0a00_0001, 16'hc001}};
  // received ICRC one off from upstream
  vecs[1] = '{32'h0a00_0001, 16'hc001, 16'd4791, 32'hdeadbeee, BTH_A, AETH_A, ICRC_A,
              3, 1'b1, VERDICT_ICRC, 1'b0, '0};
  vecs[2] = '{32'h0a00_0001, 16'hc001, 16'd4791, 32'hdeadbeef, BTH_WR, AETH_A, ICRC_A,
              3, 1'b1, VERDICT_DROP, 1'b0, '0};
  // not the RoCE v2 port
  vecs[3] = '{32'h0a00_0001, 16'hc001, 16'd4790, 32'hdeadbeef, BTH_A, AETH_A, ICRC_A,
              3, 1'b1, VERDICT_DROP, 1'b0, '0};
  vecs[4] = '{32'h0a00_0001, 16'hc001, 16'd4791, 32'hdeadbeef, BTH_A, AETH_A, ICRC_A,
              4, 1'b1, VERDICT_DROP, 1'b0, '0};
  vecs[5] = '{32'h0a00_0102, 16'hc0fe, 16'd4791, 32'h0102_0304, BTH_B, AETH_B, ICRC_B,
              3, 1'b1, VERDICT_ACCEPT, 1'b0,
              '{8'h11, 16'h1234, 24'habcdef, 1'b0, 24'h123456, 8'h60, 24'h789abc,
                32'h0a00_0102, 16'hc0fe}};
  // last on word 1
  vecs[6] = '{32'h0a00_0001, 16'hc001, 16'd4791, 32'hdeadbeef, BTH_A, AETH_A, ICRC_A,
              2, 1'b1, VERDICT_EARLY, 1'b0, '0};
  // wrong ICRC with checking off
  vecs[7] = '{32'h0a00_0102, 16'hc0fe, 16'd4791, 32'h0000_0000, BTH_B, AETH_B, ICRC_B,
              3, 1'b0, VERDICT_ACCEPT, 1'b0,
              '{8'h11, 16'h1234, 24'habcdef, 1'b0, 24'h123456, 8'h60, 24'h789abc,
                32'h0a00_0102, 16'hc0fe}};
  // output back-pressure
  vecs[8] = '{32'hc0a8_0a05, 16'hd00d, 16'd4791, 32'hdeadbeef, BTH_A, AETH_A, ICRC_A,
              3, 1'b1, VERDICT_ACCEPT, 1'b1,
              '{8'h11, 16'hffff, 24'h000123, 1'b1, 24'h00abcd, 8'h1f, 24'h000042,
                32'hc0a8_0a05, 16'hd00d}};
endtask

`endif

// File: testbench/tb_roce_rx.sv
`timescale 1ns/1ps

`include "roce_params.svh"

module tb_roce_rx
  import roce_pkg::*;
();

  logic                        clk;
  logic                        rst;
  logic                        s_hdr_valid;
  logic                        s_hdr_ready;
  ip_addr_t                    s_ip_source_ip;
  udp_port_t                   s_udp_source_port;
  udp_port_t                   s_udp_dest_port;
  icrc_t                       s_computed_icrc;
  logic                        s_payload_valid;
  logic                        s_payload_ready;
  roce_word_t                  s_payload_data;
  roce_keep_t                  s_payload_keep;
  logic                        s_payload_last;
  logic                        m_ack_valid;
  logic                        m_ack_ready;
  opcode_t                     m_ack_opcode;
  pkey_t                       m_ack_p_key;
  qpn_t                        m_ack_dest_qp;
  logic                        m_ack_ack_req;
  psn_t                        m_ack_psn;
  syndrome_t                   m_ack_syndrome;
  msn_t                        m_ack_msn;
  ip_addr_t                    m_ack_ip_source_ip;
  udp_port_t                   m_ack_udp_source_port;
  logic                        reg_req;
  logic                        reg_we;
  logic [`ROCE_REG_ADDR_W-1:0] reg_addr;
  reg_data_t                   reg_wdata;
  logic                        reg_ack;
  reg_data_t                   reg_rdata;
  logic                        busy;
  logic                        error_early_term;

  `include "tb_roce_rx_vectors.svh"

  // monitor and ready-driver state
  ack_fields_t dut_fields;
  ack_fields_t cap_fields;
  int          acks_seen;
  logic        early_seen;
  logic        hold_ready;
  logic        next_ready;
  int          errors;
  int          checks;

  assign dut_fields = {m_ack_opcode, m_ack_p_key, m_ack_dest_qp, m_ack_ack_req, m_ack_psn,
                       m_ack_syndrome, m_ack_msn, m_ack_ip_source_ip, m_ack_udp_source_port};

  roce_rx_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog allows 200 cycles per row
  initial begin
    repeat (NUM_VECS * 200) @(posedge clk);
    $display("timeout: the frame table did not finish within %0d cycles", NUM_VECS * 200);
    $display("test failed");
    $finish;
  end

  // random gaps on m_ack_ready and held low during a stall row
  initial begin
    forever begin
      @(posedge clk);
      next_ready = !hold_ready && ($urandom % 3 != 0);
      #1;
      m_ack_ready = next_ready;
    end
  end

  // mid-cycle sampling of ACK transfers and error pulses
  initial begin
    forever begin
      @(negedge clk);
      if (m_ack_valid && m_ack_ready) begin
        acks_seen++;
        cap_fields = dut_fields;
      end
      if (error_early_term) begin
        early_seen = 1'b1;
      end
    end
  end

  task automatic check_ack(input string what, input ack_fields_t got, input ack_fields_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH @%0t: %s got op %h pkey %h qp %h ackreq %b psn %h syn %h msn %h",
               $time, what, got.opcode, got.p_key, got.dest_qp, got.ack_req, got.psn,
               got.syndrome, got.msn);
      $display("  got ip %h port %h", got.ip_source_ip, got.udp_source_port);
      $display("  expected op %h pkey %h qp %h ackreq %b psn %h syn %h msn %h ip %h port %h",
               exp.opcode, exp.p_key, exp.dest_qp, exp.ack_req, exp.psn, exp.syndrome,
               exp.msn, exp.ip_source_ip, exp.udp_source_port);
    end
  endtask

  task automatic check_cnt(input string what, input stat_cnt_t got, input stat_cnt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH @%0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // four-phase access entered a step after a rising edge
  task automatic reg_access(input logic we, input logic [`ROCE_REG_ADDR_W-1:0] addr,
                            input reg_data_t wdata, output reg_data_t rdata);
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    while (!reg_ack) begin
      @(posedge clk);
      #1;
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    while (reg_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_counters(input stat_cnt_t accept_n, input stat_cnt_t drop_n,
                                input stat_cnt_t icrc_n);
    reg_data_t rd;
    reg_access(1'b0, `ROCE_REG_ACCEPT_CNT, '0, rd);
    check_cnt("accept counter", rd, accept_n);
    reg_access(1'b0, `ROCE_REG_DROP_CNT, '0, rd);
    check_cnt("drop counter", rd, drop_n);
    reg_access(1'b0, `ROCE_REG_ICRC_ERR_CNT, '0, rd);
    check_cnt("icrc error counter", rd, icrc_n);
  endtask

  task automatic set_check_en(input logic en);
    reg_data_t rd;
    reg_access(1'b1, `ROCE_REG_CFG, {15'd0, en}, rd);
    reg_access(1'b0, `ROCE_REG_CFG, '0, rd);
    check_flag("icrc check enable readback", rd[0], en);
  endtask

  task automatic send_header(input frame_vec_t v);
    s_ip_source_ip    = v.ip;
    s_udp_source_port = v.sport;
    s_udp_dest_port   = v.dport;
    s_computed_icrc   = v.calc_icrc;
    s_hdr_valid       = 1'b1;
    while (!s_hdr_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_hdr_valid = 1'b0;
    // frame now in progress
    check_flag("busy during frame", busy, 1'b1);
    check_flag("payload ready after header", s_payload_ready, 1'b1);
  endtask

  task automatic send_payload(input frame_vec_t v);
    int i;
    for (i = 0; i < v.words; i++) begin
      // idle gap of 0 to 2 cycles
      repeat ($urandom % 3) begin
        @(posedge clk);
        #1;
      end
      case (i)
        0: s_payload_data = v.w0;
        1: s_payload_data = v.w1;
        2: s_payload_data = v.w2;
        default: s_payload_data = {32'hfeed_0000, i};
      endcase
      s_payload_keep  = 8'hff;
      s_payload_last  = (i == v.words - 1);
      s_payload_valid = 1'b1;
      while (!s_payload_ready) begin
        @(posedge clk);
        #1;
      end
      @(posedge clk);
      #1;
      s_payload_valid = 1'b0;
      s_payload_last  = 1'b0;
    end
  endtask

  // ACK held against a low ready
  task automatic check_stall();
    ack_fields_t snap;
    while (!m_ack_valid) begin
      @(posedge clk);
      #1;
    end
    snap = dut_fields;
    repeat (8) begin
      @(posedge clk);
      #1;
      check_flag("ack valid held", m_ack_valid, 1'b1);
      check_flag("header ready during stall", s_hdr_ready, 1'b0);
      check_ack("held ack fields", dut_fields, snap);
    end
    hold_ready = 1'b0;
  endtask

  // idle again once a new header is allowed
  task automatic wait_idle();
    while (!s_hdr_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    frame_vec_t row;
    int         r;
    int         acks_before;
    int         seed_val;
    reg_data_t  rd;
    logic       cur_en;
    stat_cnt_t  exp_accept;
    stat_cnt_t  exp_drop;
    stat_cnt_t  exp_icrc;
    seed_val          = $urandom(32'hf55a7920);
    rst               = 1'b1;
    s_hdr_valid       = 1'b0;
    s_ip_source_ip    = '0;
    s_udp_source_port = '0;
    s_udp_dest_port   = '0;
    s_computed_icrc   = '0;
    s_payload_valid   = 1'b0;
    s_payload_data    = '0;
    s_payload_keep    = '0;
    s_payload_last    = 1'b0;
    m_ack_ready       = 1'b0;
    reg_req           = 1'b0;
    reg_we            = 1'b0;
    reg_addr          = '0;
    reg_wdata         = '0;
    hold_ready        = 1'b0;
    acks_seen         = 0;
    early_seen        = 1'b0;
    errors            = 0;
    checks            = 0;
    exp_accept        = '0;
    exp_drop          = '0;
    exp_icrc          = '0;
    load_vectors();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // reset state
    check_flag("hdr ready after reset", s_hdr_ready, 1'b0);
    check_flag("payload ready after reset", s_payload_ready, 1'b0);
    check_flag("ack valid after reset", m_ack_valid, 1'b0);
    check_flag("busy after reset", busy, 1'b0);
    check_flag("early term after reset", error_early_term, 1'b0);
    check_flag("reg ack after reset", reg_ack, 1'b0);
    reg_access(1'b0, `ROCE_REG_CFG, '0, rd);
    check_flag("icrc check enable after reset", rd[0], 1'b1);
    cur_en = 1'b1;
    check_counters(exp_accept, exp_drop, exp_icrc);

    for (r = 0; r < NUM_VECS; r++) begin
      row = vecs[r];
      if (row.check_en !== cur_en) begin
        set_check_en(row.check_en);
        cur_en = row.check_en;
      end
      acks_before = acks_seen;
      early_seen  = 1'b0;
      hold_ready  = row.hold;
      send_header(row);
      send_payload(row);
      if (row.hold) begin
        check_stall();
      end
      wait_idle();
      // counter pulses land a cycle after the event
      repeat (2) begin
        @(posedge clk);
        #1;
      end
      check_flag("busy when idle", busy, 1'b0);
      check_flag("payload ready when idle", s_payload_ready, 1'b0);

      case (row.verdict)
        VERDICT_ACCEPT: exp_accept++;
        VERDICT_ICRC:   exp_icrc++;
        default:        exp_drop++;
      endcase
      check_cnt("ack outputs", stat_cnt_t'(acks_seen - acks_before),
                (row.verdict == VERDICT_ACCEPT) ? 16'd1 : 16'd0);
      check_flag("early term pulse", early_seen, row.verdict == VERDICT_EARLY);
      if (row.verdict == VERDICT_ACCEPT) begin
        check_ack("ack fields", cap_fields, row.exp);
      end
      check_counters(exp_accept, exp_drop, exp_icrc);
    end

    $display("rows %0d  checks %0d  errors %0d", NUM_VECS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
+incdir+testbench
common/roce_pkg.sv
roce_rx/roce_rx_fsm.sv
roce_rx/roce_ack_extract.sv
roce_rx/roce_rx_regs.sv
verilog/roce_rx_top.sv
testbench/tb_roce_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the RoCE ACK receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module tb_roce_rx -o tb_roce_rx \
  && ./obj_dir/tb_roce_rx > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^test passed$" sim.log && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
